/* rv32_decode.f */
+incdir+common
common/rv32_pkg.sv
common/ctrl_if.sv
hdl/fetch_pc.sv
hdl/if_id_buffer.sv
decode/main_decoder.sv
decode/alu_decoder.sv
decode/imm_gen.sv
decode/decode_stage.sv
hdl/rv32_decode_top.sv
sim/tb_rv32_decode.sv

/* sim/tb_rv32_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32_macros.svh"

module tb_rv32_decode;
    import rv32_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int TOTAL_WORDS  = 600;  // Sum over all stream tests
    localparam int WATCHDOG_NS  = (TOTAL_WORDS * 20 + RESET_CYCLES + 40) * CLK_PERIOD;

    // Expected decode result of one accepted word
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] edge_no;   // Unstalled edge at which it was accepted
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [3:0]  alu_ctrl;
        logic [3:0]  byte_en;
        logic        reg_wr;
        logic        mem_wr;
        logic        alu_src;
        logic        a_sel;
        logic        branch;
        logic        result_src;
        logic        signed_f;
        logic        illegal;
    } expect_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        stall;
    logic        instr_valid;
    logic [31:0] instr;

    logic        dec_valid;
    addr_t       dec_pc;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    alu_ctrl_t   alu_ctrl;
    logic        reg_wr_en;
    logic        mem_wr_en;
    logic        alu_src;
    logic        alu_src_a_sel;
    logic        branch;
    logic        result_src;
    logic        signed_flag;
    byte_en_t    byte_en;
    logic        illegal;

    integer      seed = 32'hc8b2;
    expect_t     exp_q[$];
    expect_t     exp_word;
    int          pushed = 0;
    int          popped = 0;
    int          edge_count = 0;
    logic        last_stall = 1'b1;  // Edge just taken was stalled or in reset
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    string       test_name = "reset";

    rv32_decode_top rv32_decode_top_i (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .stall_i         (stall),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .dec_valid_o     (dec_valid),
        .dec_pc_o        (dec_pc),
        .rs1_o           (rs1),
        .rs2_o           (rs2),
        .rd_o            (rd),
        .imm_o           (imm),
        .alu_ctrl_o      (alu_ctrl),
        .reg_wr_en_o     (reg_wr_en),
        .mem_wr_en_o     (mem_wr_en),
        .alu_src_o       (alu_src),
        .alu_src_a_sel_o (alu_src_a_sel),
        .branch_o        (branch),
        .result_src_o    (result_src),
        .signed_o        (signed_flag),
        .byte_en_o       (byte_en),
        .illegal_o       (illegal)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    function automatic int rand_pct();
        rand_pct = ($random(seed) & 32'h7fff_ffff) % 100;
    endfunction

    function automatic logic is_legal(input logic [6:0] op);
        case (op)
            `OP_LOAD, `OP_IMM, `OP_STORE, `OP_REG, `OP_BRANCH,
            `OP_JAL, `OP_JALR, `OP_LUI, `OP_AUIPC: is_legal = 1'b1;
            default: is_legal = 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input int illegal_pct);
        logic [31:0] w;
        logic [6:0]  op;
        w = $random(seed);
        if (rand_pct() < illegal_pct) begin
            op = 7'($random(seed));
            while (is_legal(op))
                op = 7'($random(seed));
        end else begin
            case (rand_pct() % 9)
                0: op = `OP_LOAD;
                1: op = `OP_IMM;
                2: op = `OP_STORE;
                3: op = `OP_REG;
                4: op = `OP_BRANCH;
                5: op = `OP_JAL;
                6: op = `OP_JALR;
                7: op = `OP_LUI;
                default: op = `OP_AUIPC;
            endcase
        end
        w[6:0] = op;
        // Mostly canonical funct7 so SUB, SRA and SRAI show up often
        if ((op == `OP_REG || op == `OP_IMM) && rand_pct() < 80)
            w[31:25] = w[20] ? 7'h20 : 7'h00;
        make_instr = w;
    endfunction

    // funct3 operation of OP_IMM and R-type
    function automatic logic [3:0] funct_alu(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
        case (f3)
            3'd0: funct_alu = (is_reg && alt) ? ALU_SUB : ALU_ADD;
            3'd1: funct_alu = ALU_SLL;
            3'd2: funct_alu = ALU_SLT;
            3'd3: funct_alu = ALU_SLTU;
            3'd4: funct_alu = ALU_XOR;
            3'd5: funct_alu = alt ? ALU_SRA : ALU_SRL;
            3'd6: funct_alu = ALU_OR;
            default: funct_alu = ALU_AND;
        endcase
    endfunction

    function automatic logic [3:0] lanes(input logic [1:0] size);
        case (size)
            2'd0: lanes = 4'b0001;
            2'd1: lanes = 4'b0011;
            2'd2: lanes = 4'b1111;
            default: lanes = 4'b0000;
        endcase
    endfunction

    function automatic expect_t model_word(input logic [31:0] w, input int idx,
                                           input int edge_no);
        expect_t     e;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        f3    = w[14:12];
        f7    = w[31:25];
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        e          = '0;
        e.pc       = `RESET_VECTOR + 32'(4 * idx);
        e.edge_no  = edge_no;
        e.rs1      = w[19:15];
        e.rs2      = w[24:20];
        e.rd       = w[11:7];
        e.imm      = imm_i;   // Default row uses the I format and ADD
        e.alu_ctrl = ALU_ADD;
        case (w[6:0])
            `OP_LOAD: begin
                {e.reg_wr, e.alu_src, e.result_src} = 3'b111;
                e.byte_en = (f3[2] && f3[1]) ? 4'b0000 : lanes(f3[1:0]);
            end
            `OP_IMM: begin
                {e.reg_wr, e.alu_src} = 2'b11;
                e.signed_f = !(f3 == 3'd5 && f7 == 7'h00);
                if (f3 == 3'd1 || f3 == 3'd5)
                    e.imm = {27'b0, w[24:20]};
                e.alu_ctrl = funct_alu(f3, f7[5], 1'b0);
            end
            `OP_STORE: begin
                {e.mem_wr, e.alu_src, e.result_src} = 3'b111;
                e.imm      = imm_s;
                e.alu_ctrl = ALU_PASS_B;
                e.byte_en  = f3[2] ? 4'b0000 : lanes(f3[1:0]);
            end
            `OP_REG: begin
                e.reg_wr   = 1'b1;
                e.imm      = '0;
                e.alu_ctrl = funct_alu(f3, f7[5], 1'b1);
            end
            `OP_BRANCH: begin
                e.branch   = 1'b1;
                e.imm      = imm_b;
                e.alu_ctrl = f3[2] ? (f3[1] ? ALU_SLTU : ALU_SLT) : ALU_SUB;
            end
            `OP_JAL: begin
                {e.reg_wr, e.alu_src, e.a_sel, e.branch, e.result_src} = 5'b11111;
                e.imm      = imm_j;
                e.alu_ctrl = ALU_PASS_B;
            end
            `OP_JALR: {e.reg_wr, e.alu_src, e.branch, e.result_src} = 4'b1111;
            `OP_LUI, `OP_AUIPC: begin
                {e.reg_wr, e.alu_src, e.a_sel} = 3'b111;
                e.imm      = {w[31:12], 12'b0};
                e.alu_ctrl = ALU_PASS_B;
            end
            default: e.illegal = 1'b1;
        endcase
        model_word = e;
    endfunction

    // Acceptance side sees the inputs the DUT samples at this edge
    always @(posedge clk) begin
        last_stall = stall || !rst_n;
        if (rst_n && !stall) begin
            edge_count++;
            if (instr_valid) begin
                exp_q.push_back(model_word(instr, pushed, edge_count));
                pushed++;
            end
        end
    end

    // A new result follows every unstalled edge with valid high
    always @(negedge clk) begin
        if (!last_stall && dec_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Output at %0t with pc %h has no accepted word behind it",
                         $time, dec_pc);
            end else begin
                exp_word = exp_q.pop_front();
                if (popped == 0)
                    check_value("dec_pc_o", dec_pc, `RESET_VECTOR);
                // The acceptance edge counts as the first of the three
                if (edge_count - exp_word.edge_no + 1 != 3) begin
                    errors++;
                    $display("Word %0d came out on unstalled edge %0d from acceptance, not 3",
                             popped, edge_count - exp_word.edge_no + 1);
                end
                check_value("dec_pc_o", dec_pc, exp_word.pc);
                check_value("rs1_o", rs1, exp_word.rs1);
                check_value("rs2_o", rs2, exp_word.rs2);
                check_value("rd_o", rd, exp_word.rd);
                check_value("imm_o", imm, exp_word.imm);
                check_value("alu_ctrl_o", alu_ctrl, exp_word.alu_ctrl);
                check_value("reg_wr_en_o", reg_wr_en, exp_word.reg_wr);
                check_value("mem_wr_en_o", mem_wr_en, exp_word.mem_wr);
                check_value("alu_src_o", alu_src, exp_word.alu_src);
                check_value("alu_src_a_sel_o", alu_src_a_sel, exp_word.a_sel);
                check_value("branch_o", branch, exp_word.branch);
                check_value("result_src_o", result_src, exp_word.result_src);
                check_value("signed_o", signed_flag, exp_word.signed_f);
                check_value("byte_en_o", byte_en, exp_word.byte_en);
                check_value("illegal_o", illegal, exp_word.illegal);
                popped++;
            end
        end
    end

    task automatic run_stream(input string name, input int n_words, input int valid_pct,
                              input int stall_pct, input int illegal_pct);
        int   issued;
        int   err_start;
        logic held;
        logic done;
        issued    = 0;
        err_start = errors;
        done      = 1'b0;
        test_name = name;
        while (!done) begin
            @(posedge clk);
            held = instr_valid && stall;  // Word must be shown again
            if (held) begin
                stall <= (rand_pct() < stall_pct);
            end else if (issued < n_words) begin
                stall <= (rand_pct() < stall_pct);
                if (rand_pct() < valid_pct) begin
                    instr_valid <= 1'b1;
                    instr       <= make_instr(illegal_pct);
                    issued++;
                end else begin
                    instr_valid <= 1'b0;
                end
            end else begin
                instr_valid <= 1'b0;
                stall       <= 1'b0;
                done = 1'b1;
            end
        end
        @(posedge clk);
        while (popped != pushed)
            @(posedge clk);
        tests++;
        $display("Test %s done: %0d words, %0d errors", name, n_words, errors - err_start);
    endtask

    initial begin
        rst_n       = 1'b0;
        stall       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("dec_valid_o", dec_valid, 1'b0);
        end
        tests++;
        $display("Test reset done: %0d errors", errors);

        run_stream("no_stall", 200, 70, 0, 5);
        run_stream("random_stall", 300, 60, 30, 5);
        run_stream("illegal_mix", 100, 80, 15, 40);

        $display("Summary: %0d tests, %0d words, %0d checks, %0d errors",
                 tests, popped, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout in test %s, %0d of %0d accepted words came out",
                 test_name, popped, pushed);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/rv32_decode_top.sv */
`timescale 1ns/10ps
`default_nettype none

module rv32_decode_top (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           stall_i,        // Freezes all three stages
    input  wire logic           instr_valid_i,
    input  rv32_pkg::word_t     instr_i,
    output logic                dec_valid_o,
    output rv32_pkg::addr_t     dec_pc_o,
    output rv32_pkg::reg_idx_t  rs1_o,
    output rv32_pkg::reg_idx_t  rs2_o,
    output rv32_pkg::reg_idx_t  rd_o,
    output rv32_pkg::word_t     imm_o,
    output rv32_pkg::alu_ctrl_t alu_ctrl_o,
    output logic                reg_wr_en_o,
    output logic                mem_wr_en_o,
    output logic                alu_src_o,
    output logic                alu_src_a_sel_o,
    output logic                branch_o,
    output logic                result_src_o,
    output logic                signed_o,
    output rv32_pkg::byte_en_t  byte_en_o,
    output logic                illegal_o
);
    import rv32_pkg::*;

    // Fetch to buffer
    logic  f_valid;
    addr_t f_pc;
    word_t f_instr;

    // Buffer to decode
    logic  d_valid;
    addr_t d_pc;
    word_t d_instr;

    fetch_pc fetch_pc_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .stall_i       (stall_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .f_valid_o     (f_valid),
        .f_pc_o        (f_pc),
        .f_instr_o     (f_instr)
    );

    if_id_buffer if_id_buffer_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .stall_i   (stall_i),
        .f_valid_i (f_valid),
        .f_pc_i    (f_pc),
        .f_instr_i (f_instr),
        .d_valid_o (d_valid),
        .d_pc_o    (d_pc),
        .d_instr_o (d_instr)
    );

    decode_stage decode_stage_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .stall_i         (stall_i),
        .d_valid_i       (d_valid),
        .d_pc_i          (d_pc),
        .d_instr_i       (d_instr),
        .dec_valid_o     (dec_valid_o),
        .dec_pc_o        (dec_pc_o),
        .rs1_o           (rs1_o),
        .rs2_o           (rs2_o),
        .rd_o            (rd_o),
        .imm_o           (imm_o),
        .alu_ctrl_o      (alu_ctrl_o),
        .reg_wr_en_o     (reg_wr_en_o),
        .mem_wr_en_o     (mem_wr_en_o),
        .alu_src_o       (alu_src_o),
        .alu_src_a_sel_o (alu_src_a_sel_o),
        .branch_o        (branch_o),
        .result_src_o    (result_src_o),
        .signed_o        (signed_o),
        .byte_en_o       (byte_en_o),
        .illegal_o       (illegal_o)
    );

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           stall_i,
    input  wire logic           d_valid_i,
    input  rv32_pkg::addr_t     d_pc_i,
    input  rv32_pkg::word_t     d_instr_i,
    output logic                dec_valid_o,
    output rv32_pkg::addr_t     dec_pc_o,
    output rv32_pkg::reg_idx_t  rs1_o,
    output rv32_pkg::reg_idx_t  rs2_o,
    output rv32_pkg::reg_idx_t  rd_o,
    output rv32_pkg::word_t     imm_o,
    output rv32_pkg::alu_ctrl_t alu_ctrl_o,
    output logic                reg_wr_en_o,
    output logic                mem_wr_en_o,
    output logic                alu_src_o,
    output logic                alu_src_a_sel_o,
    output logic                branch_o,
    output logic                result_src_o,
    output logic                signed_o,
    output rv32_pkg::byte_en_t  byte_en_o,
    output logic                illegal_o
);
    import rv32_pkg::*;

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    word_t     imm;
    alu_ctrl_t alu_ctrl;

    ctrl_if ctrl ();

    // Standard RV32 field positions
    assign opcode = d_instr_i[6:0];
    assign funct3 = d_instr_i[14:12];
    assign funct7 = d_instr_i[31:25];

    main_decoder main_decoder_i (
        .opcode_i (opcode),
        .funct3_i (funct3),
        .funct7_i (funct7),
        .ctrl_o   (ctrl.dec)
    );

    alu_decoder alu_decoder_i (
        .alu_op_i   (ctrl.alu_op),
        .opcode_i   (opcode),
        .funct3_i   (funct3),
        .funct7_i   (funct7),
        .alu_ctrl_o (alu_ctrl)
    );

    imm_gen imm_gen_i (
        .instr_i   (d_instr_i),
        .imm_src_i (ctrl.imm_src),
        .imm_o     (imm)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            dec_valid_o <= 1'b0;
        else if (!stall_i)
            dec_valid_o <= d_valid_i;  // Held while stalled
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            dec_pc_o        <= d_pc_i;
            rs1_o           <= d_instr_i[19:15];
            rs2_o           <= d_instr_i[24:20];
            rd_o            <= d_instr_i[11:7];
            imm_o           <= imm;
            alu_ctrl_o      <= alu_ctrl;
            reg_wr_en_o     <= ctrl.reg_wr_en;
            mem_wr_en_o     <= ctrl.mem_wr_en;
            alu_src_o       <= ctrl.alu_src;
            alu_src_a_sel_o <= ctrl.alu_src_a_sel;
            branch_o        <= ctrl.branch;
            result_src_o    <= ctrl.result_src;
            signed_o        <= ctrl.signed_f;
            byte_en_o       <= ctrl.byte_en;
            illegal_o       <= ctrl.illegal;
        end
    end

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32_macros.svh"

module imm_gen (
    input  rv32_pkg::word_t    instr_i,
    input  rv32_pkg::imm_src_t imm_src_i,
    output rv32_pkg::word_t    imm_o
);

    always_comb begin
        case (imm_src_i)
            3'b000: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};                   // I
            3'b001: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};    // S
            3'b010, 3'b111: begin
                // Both B formats use the same sign extension
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            3'b011: imm_o = {instr_i[31:12], 12'b0};                               // U
            3'b100: begin
                // J format
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            3'b101: imm_o = {{(`XLEN-5){1'b0}}, instr_i[24:20]};                   // Shamt
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* decode/alu_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32_macros.svh"

module alu_decoder (
    input  rv32_pkg::alu_op_t   alu_op_i,
    input  rv32_pkg::opcode_t   opcode_i,
    input  rv32_pkg::funct3_t   funct3_i,
    input  rv32_pkg::funct7_t   funct7_i,
    output rv32_pkg::alu_ctrl_t alu_ctrl_o
);
    import rv32_pkg::*;

    alu_ctrl_t funct_op;  // Operation named by funct3 and funct7

    // Shared by OP_IMM and R-type
    always_comb begin
        case (funct3_i)
            3'b000:  funct_op = ALU_ADD;
            3'b001:  funct_op = ALU_SLL;
            3'b010:  funct_op = ALU_SLT;
            3'b011:  funct_op = ALU_SLTU;
            3'b100:  funct_op = ALU_XOR;
            3'b101:  funct_op = funct7_i[5] ? ALU_SRA : ALU_SRL;
            3'b110:  funct_op = ALU_OR;
            default: funct_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (alu_op_i)
            2'b00: alu_ctrl_o = (opcode_i == `OP_IMM) ? funct_op : ALU_ADD;
            2'b01: begin
                case (funct3_i[2:1])
                    2'b10:   alu_ctrl_o = ALU_SLT;   // BLT, BGE
                    2'b11:   alu_ctrl_o = ALU_SLTU;  // BLTU, BGEU
                    default: alu_ctrl_o = ALU_SUB;   // BEQ, BNE
                endcase
            end
            2'b10: begin
                // funct7 bit 5 only turns ADD into SUB here
                if (funct3_i == 3'b000 && funct7_i[5])
                    alu_ctrl_o = ALU_SUB;
                else
                    alu_ctrl_o = funct_op;
            end
            default: alu_ctrl_o = ALU_PASS_B;
        endcase
    end

endmodule

`default_nettype wire

/* decode/main_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32_macros.svh"

module main_decoder (
    input  rv32_pkg::opcode_t opcode_i,
    input  rv32_pkg::funct3_t funct3_i,
    input  rv32_pkg::funct7_t funct7_i,
    ctrl_if.dec               ctrl_o
);

    always_comb begin
        // Every row starts from all-zero controls
        ctrl_o.reg_wr_en     = 1'b0;
        ctrl_o.mem_wr_en     = 1'b0;
        ctrl_o.alu_src       = 1'b0;
        ctrl_o.alu_src_a_sel = 1'b0;
        ctrl_o.branch        = 1'b0;
        ctrl_o.result_src    = 1'b0;
        ctrl_o.signed_f      = 1'b0;
        ctrl_o.imm_src       = 3'b000;
        ctrl_o.alu_op        = 2'b00;
        ctrl_o.byte_en       = 4'b0000;
        ctrl_o.illegal       = 1'b0;

        case (opcode_i)
            `OP_LOAD: begin
                ctrl_o.reg_wr_en  = 1'b1;
                ctrl_o.alu_src    = 1'b1;   // Base plus offset
                ctrl_o.result_src = 1'b1;   // Data comes from memory
                // Signed flag stays 0 for every load width
                case (funct3_i)
                    3'h0, 3'h4: ctrl_o.byte_en = 4'b0001;  // LB, LBU
                    3'h1, 3'h5: ctrl_o.byte_en = 4'b0011;  // LH, LHU
                    3'h2:       ctrl_o.byte_en = 4'b1111;  // LW
                    default:    ctrl_o.byte_en = 4'b0000;
                endcase
            end

            `OP_IMM: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.signed_f  = 1'b1;
                if (funct3_i == 3'b001 || funct3_i == 3'b101)
                    ctrl_o.imm_src = 3'b101;  // Shift amount
                // SRLI is the only unsigned one
                if (funct3_i == 3'b101 && funct7_i == 7'h00)
                    ctrl_o.signed_f = 1'b0;
            end

            `OP_STORE: begin
                ctrl_o.mem_wr_en  = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.result_src = 1'b1;
                ctrl_o.imm_src    = 3'b001;
                ctrl_o.alu_op     = 2'b11;
                case (funct3_i)
                    3'b000:  ctrl_o.byte_en = 4'b0001;  // SB
                    3'b001:  ctrl_o.byte_en = 4'b0011;  // SH
                    3'b010:  ctrl_o.byte_en = 4'b1111;  // SW
                    default: ctrl_o.byte_en = 4'b0000;
                endcase
            end

            `OP_REG: begin
                ctrl_o.reg_wr_en = 1'b1;
                ctrl_o.imm_src   = 3'b110;  // No immediate
                ctrl_o.alu_op    = 2'b10;
            end

            `OP_BRANCH: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.alu_op = 2'b01;
                // BLTU and BGEU take the unsigned B format
                if (funct3_i == 3'b110 || funct3_i == 3'b111)
                    ctrl_o.imm_src = 3'b111;
                else
                    ctrl_o.imm_src = 3'b010;
            end

            `OP_JAL: begin
                ctrl_o.reg_wr_en     = 1'b1;
                ctrl_o.alu_src       = 1'b1;
                ctrl_o.alu_src_a_sel = 1'b1;  // Target is pc relative
                ctrl_o.branch        = 1'b1;
                ctrl_o.result_src    = 1'b1;
                ctrl_o.imm_src       = 3'b100;
                ctrl_o.alu_op        = 2'b11;
            end

            `OP_JALR: begin
                ctrl_o.reg_wr_en  = 1'b1;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.branch     = 1'b1;
                ctrl_o.result_src = 1'b1;
            end

            `OP_LUI, `OP_AUIPC: begin
                ctrl_o.reg_wr_en     = 1'b1;
                ctrl_o.alu_src       = 1'b1;
                ctrl_o.alu_src_a_sel = 1'b1;
                ctrl_o.imm_src       = 3'b011;
                ctrl_o.alu_op        = 2'b11;  // ALU passes the upper immediate
            end

            default: ctrl_o.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/if_id_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module if_id_buffer (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,
    input  wire logic       stall_i,   // Holds the slot
    input  wire logic       f_valid_i,
    input  rv32_pkg::addr_t f_pc_i,
    input  rv32_pkg::word_t f_instr_i,
    output logic            d_valid_o,
    output rv32_pkg::addr_t d_pc_o,
    output rv32_pkg::word_t d_instr_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            d_valid_o <= 1'b0;
        else if (!stall_i)
            d_valid_o <= f_valid_i;
    end

    // Payload follows the valid bit
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            d_pc_o    <= f_pc_i;
            d_instr_o <= f_instr_i;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_pc.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv32_macros.svh"

module fetch_pc (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            stall_i,
    input  wire logic            instr_valid_i,  // One strobe per word
    input  rv32_pkg::word_t      instr_i,
    output logic                 f_valid_o,
    output rv32_pkg::addr_t      f_pc_o,
    output rv32_pkg::word_t      f_instr_o
);
    import rv32_pkg::*;

    addr_t pc_q;   // Address of the next word to arrive
    logic  accept;

    assign accept = instr_valid_i && !stall_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q      <= `RESET_VECTOR;
            f_valid_o <= 1'b0;
        end else if (!stall_i) begin
            f_valid_o <= instr_valid_i;
            if (accept)
                pc_q <= pc_q + addr_t'(4);  // Always sequential since nothing redirects
        end
    end

    // Word is tagged with the pc it was fetched at
    always_ff @(posedge clk_i) begin
        if (accept) begin
            f_pc_o    <= pc_q;
            f_instr_o <= instr_i;
        end
    end

endmodule

`default_nettype wire

/* common/ctrl_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface ctrl_if;
    import rv32_pkg::*;

    logic     reg_wr_en;
    logic     mem_wr_en;
    logic     alu_src;        // Operand b is the immediate
    logic     alu_src_a_sel;  // Operand a is the pc
    logic     branch;
    logic     result_src;     // Result from memory or link path
    logic     signed_f;
    imm_src_t imm_src;
    alu_op_t  alu_op;
    byte_en_t byte_en;
    logic     illegal;        // Opcode not in the table

    modport dec (
        output reg_wr_en, mem_wr_en, alu_src, alu_src_a_sel, branch, result_src,
               signed_f, imm_src, alu_op, byte_en, illegal
    );

    modport stage (
        input reg_wr_en, mem_wr_en, alu_src, alu_src_a_sel, branch, result_src,
              signed_f, imm_src, alu_op, byte_en, illegal
    );

endinterface

`default_nettype wire

/* common/rv32_pkg.sv */
`default_nettype none

`include "rv32_macros.svh"

package rv32_pkg;

    // Data path words
    typedef logic [`XLEN-1:0] word_t;  // Instruction or immediate
    typedef logic [`XLEN-1:0] addr_t;  // Program counter

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;
    typedef logic [4:0] reg_idx_t;

    // Immediate format select
    // 000 I, 001 S, 010 B, 011 U, 100 J, 101 shamt, 110 none, 111 B unsigned
    typedef logic [2:0] imm_src_t;

    // Coarse ALU class from the main decoder
    // 00 add or op-imm, 01 branch compare, 10 R-type, 11 pass operand b
    typedef logic [1:0] alu_op_t;

    typedef logic [3:0] byte_en_t;   // One bit per byte lane
    typedef logic [3:0] alu_ctrl_t;  // Code seen by the ALU

    // ALU control codes
    localparam alu_ctrl_t ALU_ADD    = 4'd0;
    localparam alu_ctrl_t ALU_SUB    = 4'd1;
    localparam alu_ctrl_t ALU_AND    = 4'd2;
    localparam alu_ctrl_t ALU_OR     = 4'd3;
    localparam alu_ctrl_t ALU_XOR    = 4'd4;
    localparam alu_ctrl_t ALU_SLL    = 4'd5;
    localparam alu_ctrl_t ALU_SRL    = 4'd6;
    localparam alu_ctrl_t ALU_SRA    = 4'd7;
    localparam alu_ctrl_t ALU_SLT    = 4'd8;   // Signed compare
    localparam alu_ctrl_t ALU_SLTU   = 4'd9;   // Unsigned compare
    localparam alu_ctrl_t ALU_PASS_B = 4'd10;  // Result is operand b

endpackage

`default_nettype wire

/* common/rv32_macros.svh */
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

`define XLEN         32
`define RESET_VECTOR 32'h0000_0000  // First fetch address

// Base opcodes of the RV32I subset
`define OP_LOAD   7'b0000011
`define OP_IMM    7'b0010011
`define OP_STORE  7'b0100011
`define OP_REG    7'b0110011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111

`endif
